/* hw/cp0_macros.svh */
`ifndef CP0_MACROS_SVH
`define CP0_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// CP0 register numbers as seen by mtc0 and mfc0
//////////////////////////////////////////////////////////////////////

// Status register
`define CP0_SR 5'd12

// Cause register
`define CP0_CAUSE 5'd13

// Exception program counter
`define CP0_EPC 5'd14

//////////////////////////////////////////////////////////////////////
// Exception entry and interrupt input
//////////////////////////////////////////////////////////////////////

// Common handler vector for every exception and interrupt
`define CP0_HANDLER 32'h0000_4180

// Flop depth of the hwInt synchroniser
`define INT_SYNC_STAGES 2

`endif

/* hw/cp0Pkg.sv */
`default_nettype none

package cp0Pkg;

    //////////////////////////////////////////////////////////////////
    // Exception codes as stored in Cause.excCode
    //////////////////////////////////////////////////////////////////
    typedef enum logic [4:0] {
        excInt  = 5'd0,   // External interrupt
        excAdEL = 5'd4,   // Address error on fetch or load
        excAdES = 5'd5,   // Address error on store
        excSys  = 5'd8,   // Syscall
        excRI   = 5'd10,  // Reserved instruction
        excOv   = 5'd12   // Arithmetic overflow
    } excCodeE;

    // Status, architectural layout, unused bits read as zero
    typedef struct packed {
        logic [15:0] zero31To16;
        logic [5:0]  im;          // Per-line interrupt mask
        logic [7:0]  zero9To2;
        logic        exl;         // Exception level
        logic        ie;          // Global interrupt enable
    } statusT;

    // Cause, architectural layout
    typedef struct packed {
        logic        bd;          // Victim sat in a delay slot
        logic [14:0] zero30To16;
        logic [5:0]  ip;          // Pending hardware interrupts
        logic [2:0]  zero9To7;
        excCodeE     excCode;
        logic [1:0]  zero1To0;
    } causeT;

    // PC redirect towards the fetch stage
    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } redirectT;

endpackage

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

    //////////////////////////////////////////////////////////////////
    // Class of the instruction leaving the pipeline
    //////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        opAlu,
        opLoad,
        opStore,
        opMtc0,
        opMfc0,
        opEret,
        opSyscall,
        opIllegal
    } opClassE;

    // One retiring instruction, valid is a one-cycle strobe
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        delaySlot;   // Instruction follows a branch
        opClassE     op;
        logic        overflow;    // Signed add/sub overflowed
        logic [31:0] memAddr;     // Effective address of load/store
        logic [4:0]  cp0Reg;      // Target register of mtc0
        logic [31:0] wData;       // Source value of mtc0
    } commitT;

endpackage

`default_nettype wire

/* hw/excCollector.sv */
`default_nettype none

`include "cp0_macros.svh"

module excCollector (
    input  logic              clk,
    input  logic              reset,
    input  pipePkg::commitT   commit,
    input  logic [5:0]        hwInt,
    output logic              fault,
    output cp0Pkg::excCodeE   excCode,
    output logic              eret,
    output logic              mtc0,
    output logic [5:0]        intSync
);

    //////////////////////////////////////////////////////////////////
    // Interrupt synchroniser
    //////////////////////////////////////////////////////////////////

    // Stage 0 samples the raw lines
    logic [`INT_SYNC_STAGES-1:0][5:0] syncQ;

    always_ff @(posedge clk) begin
        if (reset) begin
            syncQ <= '0;
        end else begin
            syncQ[0] <= hwInt;
            for (int i = 1; i < `INT_SYNC_STAGES; i++) begin
                syncQ[i] <= syncQ[i-1];
            end
        end
    end

    // Last stage feeds Cause.ip and the request logic
    assign intSync = syncQ[`INT_SYNC_STAGES-1];

    //////////////////////////////////////////////////////////////////
    // Fault detection
    //////////////////////////////////////////////////////////////////

    logic pcMisaligned;
    logic memMisaligned;

    // Word accesses only
    assign pcMisaligned  = |commit.pc[1:0];
    assign memMisaligned = |commit.memAddr[1:0];

    // Priority chain, earliest pipeline stage first
    always_comb begin
        fault   = 1'b0;
        excCode = cp0Pkg::excInt;
        if (commit.valid) begin
            fault = 1'b1;
            if (pcMisaligned) begin
                excCode = cp0Pkg::excAdEL;
            end else if (commit.op == pipePkg::opIllegal) begin
                excCode = cp0Pkg::excRI;
            end else if (commit.op == pipePkg::opSyscall) begin
                excCode = cp0Pkg::excSys;
            end else if (commit.op == pipePkg::opAlu && commit.overflow) begin
                excCode = cp0Pkg::excOv;
            end else if (commit.op == pipePkg::opLoad && memMisaligned) begin
                excCode = cp0Pkg::excAdEL;
            end else if (commit.op == pipePkg::opStore && memMisaligned) begin
                excCode = cp0Pkg::excAdES;
            end else begin
                // Clean instruction
                fault = 1'b0;
            end
        end
    end

    // Op strobes, dropped when the same instruction faults
    assign eret = commit.valid && !fault && (commit.op == pipePkg::opEret);
    assign mtc0 = commit.valid && !fault && (commit.op == pipePkg::opMtc0);

endmodule

`default_nettype wire

/* hw/cp0Regs.sv */
`default_nettype none

`include "cp0_macros.svh"

module cp0Regs (
    input  logic              clk,
    input  logic              reset,
    input  pipePkg::commitT   commit,
    input  logic              fault,
    input  cp0Pkg::excCodeE   excCode,
    input  logic              eret,
    input  logic              mtc0,
    input  logic [5:0]        intSync,
    input  logic [4:0]        rdReg,
    output logic [31:0]       rdData,
    output cp0Pkg::redirectT  redirect
);

    //////////////////////////////////////////////////////////////////
    // Architectural state
    //////////////////////////////////////////////////////////////////

    cp0Pkg::statusT  status;
    cp0Pkg::causeT   cause;
    logic [31:0]     epc;

    //////////////////////////////////////////////////////////////////
    // Request logic
    //////////////////////////////////////////////////////////////////

    logic            faultReq;
    logic            intReq;
    logic            takeReq;
    cp0Pkg::excCodeE takeCode;
    logic [31:0]     epcNext;
    cp0Pkg::statusT  wrStatus;

    // No new exception while already in the handler
    assign faultReq = !status.exl && fault;

    // Enabled and unmasked line pending
    assign intReq = !status.exl && status.ie && (|(intSync & status.im));

    // eret wins over both request kinds
    assign takeReq = (faultReq || intReq) && !eret;

    // Fault code beats interrupt
    assign takeCode = faultReq ? excCode : cp0Pkg::excInt;

    // Restart at the branch when the victim is in its delay slot
    assign epcNext = commit.delaySlot ? (commit.pc - 32'd4) : commit.pc;

    // Status write image, only the implemented fields
    always_comb begin
        wrStatus     = '0;
        wrStatus.im  = commit.wData[15:10];
        wrStatus.exl = commit.wData[1];
        wrStatus.ie  = commit.wData[0];
    end

    //////////////////////////////////////////////////////////////////
    // Register update
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            status <= '0;
            cause  <= '0;
            epc    <= '0;
        end else begin
            // Pending lines tracked every cycle
            cause.ip <= intSync;
            if (eret) begin
                status.exl <= 1'b0;
            end else if (takeReq) begin
                status.exl    <= 1'b1;
                cause.bd      <= commit.delaySlot;
                cause.excCode <= takeCode;
                epc           <= epcNext;
            end else if (mtc0) begin
                // Cause is read-only from software here
                case (commit.cp0Reg)
                    `CP0_SR:  status <= wrStatus;
                    `CP0_EPC: epc <= commit.wData;
                    default:  ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // mfc0 read port
    //////////////////////////////////////////////////////////////////

    always_comb begin
        case (rdReg)
            `CP0_SR:    rdData = status;
            `CP0_CAUSE: rdData = cause;
            `CP0_EPC:   rdData = epc;
            default:    rdData = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////
    // Redirect
    //////////////////////////////////////////////////////////////////

    // Same cycle as the trigger, handler vector or saved EPC
    always_comb begin
        redirect.valid  = eret || takeReq;
        redirect.target = eret ? epc : `CP0_HANDLER;
    end

endmodule

`default_nettype wire

/* hw/excTop.sv */
`default_nettype none

module excTop (
    input  logic              clk,
    input  logic              reset,
    input  pipePkg::commitT   commit,
    input  logic [5:0]        hwInt,
    input  logic [4:0]        rdReg,
    output logic [31:0]       rdData,
    output cp0Pkg::redirectT  redirect
);

    // Collector to register block
    logic            fault;
    cp0Pkg::excCodeE excCode;
    logic            eret;
    logic            mtc0;
    logic [5:0]      intSync;

    // Fault classification and interrupt sync
    excCollector collector (
        .clk     (clk),
        .reset   (reset),
        .commit  (commit),
        .hwInt   (hwInt),
        .fault   (fault),
        .excCode (excCode),
        .eret    (eret),
        .mtc0    (mtc0),
        .intSync (intSync)
    );

    // Status, Cause, EPC and redirect
    cp0Regs regs (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .fault    (fault),
        .excCode  (excCode),
        .eret     (eret),
        .mtc0     (mtc0),
        .intSync  (intSync),
        .rdReg    (rdReg),
        .rdData   (rdData),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

/* verif/excTop_sva.sv */
`default_nettype none

`include "cp0_macros.svh"

module excTopChecker (
    input logic             clk,
    input logic             reset,
    input pipePkg::commitT  commit,
    input logic [5:0]       hwInt,
    input logic [4:0]       rdReg,
    input logic [31:0]      rdData,
    input cp0Pkg::redirectT redirect
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failure tally, read by the testbench at the end
    int failCount = 0;

    logic        hasFault;
    logic        faulting;
    logic [4:0]  expCode;
    logic [31:0] expEpc;
    logic        eretOk;
    logic        mtc0Ok;
    logic        reqSeen;
    // Shadow Status and EPC
    logic        exlM;
    logic        ieM;
    logic [5:0]  imM;
    logic [31:0] epcM;

    task automatic countFailure(input string what);
        failCount++;
        $error("%s", what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Expected classification of the retiring instruction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        hasFault = 1'b1;
        expCode  = 5'd0;
        if (commit.pc[1:0] != 2'b00) begin
            expCode = cp0Pkg::excAdEL;
        end else if (commit.op == pipePkg::opIllegal) begin
            expCode = cp0Pkg::excRI;
        end else if (commit.op == pipePkg::opSyscall) begin
            expCode = cp0Pkg::excSys;
        end else if (commit.op == pipePkg::opAlu && commit.overflow) begin
            expCode = cp0Pkg::excOv;
        end else if (commit.op == pipePkg::opLoad && commit.memAddr[1:0] != 2'b00) begin
            expCode = cp0Pkg::excAdEL;
        end else if (commit.op == pipePkg::opStore && commit.memAddr[1:0] != 2'b00) begin
            expCode = cp0Pkg::excAdES;
        end else begin
            hasFault = 1'b0;
        end
    end

    assign faulting = commit.valid && hasFault;
    assign expEpc   = commit.delaySlot ? commit.pc - 32'd4 : commit.pc;
    assign eretOk   = commit.valid && !hasFault && commit.op == pipePkg::opEret;
    // Interrupt taken in the same cycle also kills the write
    assign mtc0Ok   = commit.valid && !hasFault && commit.op == pipePkg::opMtc0
                      && !redirect.valid;
    assign reqSeen  = redirect.valid && !eretOk;

    // Shadow of the architectural state
    always_ff @(posedge clk) begin
        if (reset) begin
            exlM <= 1'b0;
            ieM  <= 1'b0;
            imM  <= '0;
            epcM <= '0;
        end else if (reqSeen) begin
            exlM <= 1'b1;
            epcM <= expEpc;
        end else if (eretOk) begin
            exlM <= 1'b0;
        end else if (mtc0Ok && commit.cp0Reg == `CP0_SR) begin
            exlM <= commit.wData[1];
            ieM  <= commit.wData[0];
            imM  <= commit.wData[15:10];
        end else if (mtc0Ok && commit.cp0Reg == `CP0_EPC) begin
            epcM <= commit.wData;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Request, priority, EPC and eret properties
    //////////////////////////////////////////////////////////////////////

    faultRedirect: assert property (@(posedge clk) disable iff (reset)
        faulting && !exlM |-> redirect.valid)
        else countFailure("Fault outside the handler gave no redirect");

    // Held off while exl is set
    blockedInHandler: assert property (@(posedge clk) disable iff (reset)
        faulting && exlM |-> !redirect.valid)
        else countFailure("Fault inside the handler still redirected");

    intRedirect: assert property (@(posedge clk) disable iff (reset)
        !faulting && !eretOk |->
            redirect.valid == (ieM && !exlM && |($past(hwInt, `INT_SYNC_STAGES) & imM)))
        else countFailure("Interrupt redirect does not follow ie, im and exl");

    handlerTarget: assert property (@(posedge clk) disable iff (reset)
        reqSeen |-> redirect.target == `CP0_HANDLER)
        else countFailure("Exception redirect not aimed at the handler vector");

    causeRecord: assert property (@(posedge clk) disable iff (reset)
        reqSeen |=> rdReg != `CP0_CAUSE ||
            (rdData[6:2] == $past(faulting ? expCode : 5'd0)
             && rdData[31] == $past(commit.delaySlot)))
        else countFailure("Cause code or bd wrong after a request");

    epcRecord: assert property (@(posedge clk) disable iff (reset)
        reqSeen |=> rdReg != `CP0_EPC || rdData == $past(expEpc))
        else countFailure("EPC wrong after a request");

    eretReturn: assert property (@(posedge clk) disable iff (reset)
        eretOk |-> redirect.valid && redirect.target == epcM)
        else countFailure("eret did not return to EPC");

    eretClear: assert property (@(posedge clk) disable iff (reset)
        eretOk |=> rdReg != `CP0_SR || !rdData[1])
        else countFailure("exl still set after eret");

    // ip lags hwInt by the sync depth plus the Cause flop
    ipTrack: assert property (@(posedge clk) disable iff (reset)
        rdReg == `CP0_CAUSE |-> rdData[15:10] == $past(hwInt, `INT_SYNC_STAGES + 1))
        else countFailure("Cause.ip does not follow the interrupt lines");

endmodule

bind excTop excTopChecker propCheck (
    .clk      (clk),
    .reset    (reset),
    .commit   (commit),
    .hwInt    (hwInt),
    .rdReg    (rdReg),
    .rdData   (rdData),
    .redirect (redirect)
);

`default_nettype wire

/* verif/excTb.sv */
`default_nettype none

`include "cp0_macros.svh"

module excTb;

    timeunit 1ns;
    timeprecision 1ps;

    // Roughly twice the length of all tests
    localparam int MAX_CYCLES = 400;

    logic             clk = 1'b0;
    logic             reset;
    pipePkg::commitT  commit;
    logic [5:0]       hwInt;
    logic [4:0]       rdReg;
    logic [31:0]      rdData;
    cp0Pkg::redirectT redirect;

    integer          seed;
    int              cycles = 0;
    int              tbErrors = 0;
    int              testsRun = 0;
    int              testsFailed = 0;
    int              errorsAtStart;
    string           testName;
    logic            seen;
    pipePkg::commitT c;
    logic [31:0]     savedPc;

    excTop uut (
        .clk      (clk),
        .reset    (reset),
        .commit   (commit),
        .hwInt    (hwInt),
        .rdReg    (rdReg),
        .rdData   (rdData),
        .redirect (redirect)
    );

    always #2 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic int errorCount();
        return tbErrors + uut.propCheck.failCount;
    endfunction

    // Word-aligned random address
    function automatic logic [31:0] randAddr();
        return $random(seed) & 32'h0FFF_FFFC;
    endfunction

    function automatic pipePkg::commitT makeCommit(pipePkg::opClassE op, logic [31:0] pc);
        pipePkg::commitT r;
        r       = '0;
        r.valid = 1'b1;
        r.op    = op;
        r.pc    = pc;
        return r;
    endfunction

    // One-cycle commit strobe, rdReg parked on a register of interest
    task automatic sendCommit(input pipePkg::commitT ci, input logic [4:0] watch = 5'd0);
        @(negedge clk);
        commit = ci;
        rdReg  = watch;
        @(negedge clk);
        commit = '0;
    endtask

    task automatic writeCp0(input logic [4:0] regNum, input logic [31:0] value);
        pipePkg::commitT w;
        w        = makeCommit(pipePkg::opMtc0, randAddr());
        w.cp0Reg = regNum;
        w.wData  = value;
        sendCommit(w);
    endtask

    task automatic readCheck(input logic [4:0] regNum, input logic [31:0] expected,
                             input logic [31:0] mask, input string what);
        logic [31:0] got;
        @(negedge clk);
        rdReg = regNum;
        #1;
        got = rdData;
        assert ((got & mask) == (expected & mask))
        else begin
            $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what,
                     got & mask, expected & mask);
            tbErrors++;
        end
    endtask

    task automatic waitRedirect(input int limit, output logic hit);
        hit = 1'b0;
        for (int i = 0; i < limit && !hit; i++) begin
            @(negedge clk);
            #1;
            hit = redirect.valid;
        end
    endtask

    // Fault, readback of Cause, Status and EPC, then eret out of the handler
    task automatic faultCase(input pipePkg::commitT ci, input logic [4:0] code,
                             input logic [4:0] watch, input string what);
        logic [31:0] epcExp;
        epcExp = ci.delaySlot ? ci.pc - 32'd4 : ci.pc;
        sendCommit(ci, watch);
        readCheck(`CP0_CAUSE, {ci.delaySlot, 24'd0, code, 2'b00}, '1, what);
        readCheck(`CP0_SR, 32'h0000_0002, '1, what);
        readCheck(`CP0_EPC, epcExp, '1, what);
        sendCommit(makeCommit(pipePkg::opEret, randAddr()), `CP0_SR);
        readCheck(`CP0_SR, 32'h0, '1, what);
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorCount();
    endtask

    task automatic endTest();
        int newErrors;
        // Let the |=> properties of the last cycle settle
        repeat (2) @(negedge clk);
        newErrors = errorCount() - errorsAtStart;
        testsRun++;
        if (newErrors == 0) begin
            $display("test %s: passed", testName);
        end else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", testName, newErrors);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed   = 32'hd770_26f5;
        reset  = 1'b1;
        commit = '0;
        hwInt  = '0;
        rdReg  = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        startTest("reset and mtc0");
        waitRedirect(3, seen);
        if (seen) begin
            $display("Redirect raised with no commit right after reset");
            tbErrors++;
        end
        readCheck(`CP0_SR, 32'h0, '1, "Status after reset");
        readCheck(`CP0_CAUSE, 32'h0, '1, "Cause after reset");
        readCheck(`CP0_EPC, 32'h0, '1, "EPC after reset");
        // Only im, exl and ie are implemented
        writeCp0(`CP0_SR, 32'hFFFF_FFFC);
        readCheck(`CP0_SR, 32'h0000_FC00, '1, "Status write");
        writeCp0(`CP0_SR, 32'h0);
        writeCp0(`CP0_EPC, 32'h1234_5678);
        readCheck(`CP0_EPC, 32'h1234_5678, '1, "EPC write");
        writeCp0(`CP0_CAUSE, 32'hFFFF_FFFF);
        readCheck(`CP0_CAUSE, 32'h0, '1, "Cause write ignored");
        readCheck(5'd3, 32'h0, '1, "unknown register");
        endTest();

        startTest("fault priority");
        c = makeCommit(pipePkg::opAlu, randAddr() | 32'd2);
        faultCase(c, cp0Pkg::excAdEL, `CP0_CAUSE, "misaligned fetch");
        faultCase(makeCommit(pipePkg::opIllegal, randAddr()), cp0Pkg::excRI, `CP0_EPC,
                  "reserved instruction");
        faultCase(makeCommit(pipePkg::opSyscall, randAddr()), cp0Pkg::excSys, `CP0_CAUSE,
                  "syscall");
        c = makeCommit(pipePkg::opAlu, randAddr());
        c.overflow = 1'b1;
        faultCase(c, cp0Pkg::excOv, `CP0_EPC, "overflow");
        c = makeCommit(pipePkg::opLoad, randAddr());
        c.memAddr = randAddr() | 32'd1;
        faultCase(c, cp0Pkg::excAdEL, `CP0_CAUSE, "misaligned load");
        c = makeCommit(pipePkg::opStore, randAddr());
        c.memAddr = randAddr() | 32'd3;
        faultCase(c, cp0Pkg::excAdES, `CP0_EPC, "misaligned store");
        // Two faults at once, the fetch error wins
        faultCase(makeCommit(pipePkg::opIllegal, randAddr() | 32'd1), cp0Pkg::excAdEL,
                  `CP0_CAUSE, "fetch error over reserved");
        c = makeCommit(pipePkg::opAlu, randAddr() | 32'h10);
        c.overflow  = 1'b1;
        c.delaySlot = 1'b1;
        faultCase(c, cp0Pkg::excOv, `CP0_EPC, "overflow in delay slot");
        endTest();

        startTest("exl and eret");
        // Faulting mtc0 must not reach Status
        c = makeCommit(pipePkg::opMtc0, randAddr() | 32'd1);
        c.cp0Reg = `CP0_SR;
        c.wData  = 32'h0000_FC01;
        savedPc  = c.pc;
        sendCommit(c, `CP0_CAUSE);
        readCheck(`CP0_SR, 32'h0000_0002, '1, "Status after faulting mtc0");
        readCheck(`CP0_CAUSE, {27'd0, 5'(cp0Pkg::excAdEL)} << 2, '1, "Cause of faulting mtc0");
        sendCommit(makeCommit(pipePkg::opIllegal, randAddr()), `CP0_EPC);
        readCheck(`CP0_EPC, savedPc, '1, "EPC kept while in handler");
        // Faulting EPC write inside the handler
        c = makeCommit(pipePkg::opMtc0, randAddr() | 32'd2);
        c.cp0Reg = `CP0_EPC;
        c.wData  = 32'hDEAD_BEE0;
        sendCommit(c, `CP0_EPC);
        readCheck(`CP0_EPC, savedPc, '1, "EPC after faulting mtc0");
        // Back to the first victim
        sendCommit(makeCommit(pipePkg::opEret, randAddr()), `CP0_SR);
        readCheck(`CP0_SR, 32'h0, '1, "Status after eret");
        endTest();

        startTest("interrupt");
        writeCp0(`CP0_SR, 32'h0000_1001);
        @(negedge clk);
        hwInt = 6'b000100;
        waitRedirect(`INT_SYNC_STAGES + 4, seen);
        if (!seen) begin
            $display("No redirect after raising hwInt[2] with it unmasked");
            tbErrors++;
        end
        readCheck(`CP0_CAUSE, 32'h0, 32'h8000_007C, "Cause after interrupt");
        readCheck(`CP0_SR, 32'h0000_1003, '1, "Status after interrupt");
        @(negedge clk);
        hwInt = '0;
        repeat (4) @(negedge clk);
        sendCommit(makeCommit(pipePkg::opEret, randAddr()), `CP0_SR);
        // Line 3 enabled only, line 2 must stay silent
        writeCp0(`CP0_SR, 32'h0000_2001);
        @(negedge clk);
        hwInt = 6'b000100;
        waitRedirect(8, seen);
        if (seen) begin
            $display("Masked interrupt line still caused a redirect");
            tbErrors++;
        end
        @(negedge clk);
        hwInt = '0;
        repeat (4) @(negedge clk);
        writeCp0(`CP0_SR, 32'h0);
        endTest();

        startTest("pending lines");
        @(negedge clk);
        hwInt = 6'b101101;
        repeat (`INT_SYNC_STAGES + 2) @(negedge clk);
        readCheck(`CP0_CAUSE, {16'd0, 6'b101101, 10'd0}, 32'h0000_FC00, "Cause.ip");
        @(negedge clk);
        hwInt = 6'b010010;
        repeat (`INT_SYNC_STAGES + 2) @(negedge clk);
        readCheck(`CP0_CAUSE, {16'd0, 6'b010010, 10'd0}, 32'h0000_FC00, "Cause.ip");
        @(negedge clk);
        hwInt = '0;
        endTest();

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount());
        if (errorCount() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hw
hw/cp0Pkg.sv
hw/pipePkg.sv
hw/excCollector.sv
hw/cp0Regs.sv
hw/excTop.sv
verif/excTop_sva.sv
verif/excTb.sv

/* Bender.yml */
package:
  name: exc_cp0

sources:
  - include_dirs:
      - hw
    files:
      - hw/cp0Pkg.sv
      - hw/pipePkg.sv
      - hw/excCollector.sv
      - hw/cp0Regs.sv
      - hw/excTop.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/excTop_sva.sv
      - verif/excTb.sv
